//--- hw/sorted_lists_pkg.sv
// Shared types for the sorted list engine, referenced by scoped name from every RTL block
package sorted_lists_pkg;

  // Sort key and payload of one entry
  typedef logic [63:0] key_t;
  typedef logic [31:0] size_t;

  // List identifier, up to 64 lists
  typedef logic [5:0] id_t;

  // Position in ascending key order, 0 is the smallest key
  typedef logic [7:0] level_t;

  // Number of valid entries in one list
  typedef logic [7:0] listsize_t;

  // Update opcodes
  typedef enum logic [1:0] {
    OP_CLEAR   = 2'b00,
    OP_ADD     = 2'b01,
    OP_DELETE  = 2'b10,
    OP_REPLACE = 2'b11
  } upt_op_t;

  // Update command as seen on the input port
  typedef struct packed {
    id_t     id;
    upt_op_t op;
    key_t    key;
    size_t   size;
  } upt_cmd_t;

  // One slot of a list, a list is an array of these
  typedef struct packed {
    logic  vld;
    key_t  key;
    size_t size;
  } entry_t;

  // Query command
  typedef struct packed {
    id_t    id;
    level_t level;
  } qry_cmd_t;

  // Query response, payload fields are zero on error
  typedef struct packed {
    id_t       id;
    key_t      key;
    size_t     size;
    logic      error;
    listsize_t listsize;
  } qry_resp_t;

  // Empty-list notification, echoes the triggering command
  typedef struct packed {
    id_t   id;
    key_t  key;
    size_t size;
  } ntf_t;

endpackage

//--- hw/list_table.sv
// Flop-based store of every list, two registered read ports and one write port with bypass
`timescale 1ns/1ps

module list_table #(
  parameter int num_entries = 8,
  parameter int num_lists   = 64
) (
  input  logic                                       clk,
  input  logic                                       rst,
  // Read port used by the update engine
  input  sorted_lists_pkg::id_t                      rd0_addr,
  output sorted_lists_pkg::entry_t [num_entries-1:0] rd0_data,
  // Read port used by the query engine
  input  sorted_lists_pkg::id_t                      rd1_addr,
  output sorted_lists_pkg::entry_t [num_entries-1:0] rd1_data,
  // Write-back from the update engine
  input  logic                                       wr_en,
  input  sorted_lists_pkg::id_t                      wr_addr,
  input  sorted_lists_pkg::entry_t [num_entries-1:0] wr_data
);

  // Whole state of one list
  typedef sorted_lists_pkg::entry_t [num_entries-1:0] row_t;

  // One row per list
  row_t mem [num_lists];

  // Write-first read, a write to the same list on this edge wins over the array
  function automatic row_t read_row(input sorted_lists_pkg::id_t addr);
    row_t row;
    if (wr_en && (wr_addr == addr)) begin
      row = wr_data;
    end else begin
      row = mem[addr];
    end
    return row;
  endfunction

  // Write port
  always_ff @(posedge clk) begin
    if (rst) begin
      // Only the valid bits need clearing, keys and sizes are don't care
      for (int l = 0; l < num_lists; l++) begin
        for (int e = 0; e < num_entries; e++) begin
          mem[l][e].vld <= 1'b0;
        end
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Both read ports sample every cycle
  // Data appears one cycle after the address
  always_ff @(posedge clk) begin
    rd0_data <= read_row(rd0_addr);
    rd1_data <= read_row(rd1_addr);
  end

endmodule

//--- hw/update_engine.sv
// Update pipeline: captures CLEAR/ADD/DELETE/REPLACE, executes against the table row, writes back
`timescale 1ns/1ps

module update_engine #(
  parameter int num_entries = 8
) (
  input  logic                                       clk,
  input  logic                                       rst,
  // Command input, one per cycle when upt_vld is high
  input  logic                                       upt_vld,
  input  sorted_lists_pkg::upt_cmd_t                 upt,
  // Table read port 0
  output sorted_lists_pkg::id_t                      rd0_addr,
  input  sorted_lists_pkg::entry_t [num_entries-1:0] rd0_data,
  // Table write port
  output logic                                       wr_en,
  output sorted_lists_pkg::id_t                      wr_addr,
  output sorted_lists_pkg::entry_t [num_entries-1:0] wr_data,
  // Error and notification outputs
  output logic                                       upt_error_vld,
  output sorted_lists_pkg::id_t                      upt_error_id,
  output logic                                       ntf_vld,
  output sorted_lists_pkg::ntf_t                     ntf
);

  // Slot index width
  localparam int idx_w = $clog2(num_entries);

  // Stage 0 holds the command while the table read is in flight
  logic                                       s0_vld;
  sorted_lists_pkg::upt_cmd_t                 s0_cmd;
  // Stage 1 lines up with rd0_data and executes
  logic                                       s1_vld;
  sorted_lists_pkg::upt_cmd_t                 s1_cmd;

  // Slot search results
  logic                                       has_free;
  logic                                       has_match;
  logic [idx_w-1:0]                           free_idx;
  logic [idx_w-1:0]                           match_idx;
  sorted_lists_pkg::listsize_t                vld_cnt;

  // Execution results
  logic                                       err;
  logic                                       empty_ntf;
  sorted_lists_pkg::entry_t [num_entries-1:0] nxt;

  // Stage valids
  always_ff @(posedge clk) begin
    if (rst) begin
      s0_vld <= 1'b0;
      s1_vld <= 1'b0;
    end else begin
      s0_vld <= upt_vld;
      s1_vld <= s0_vld;
    end
  end

  // Stage payloads, loaded only with a live command
  always_ff @(posedge clk) begin
    if (upt_vld) begin
      s0_cmd <= upt;
    end
    if (s0_vld) begin
      s1_cmd <= s0_cmd;
    end
  end

  // Table read issued from stage 0
  assign rd0_addr = s0_cmd.id;

  // Find first free slot, first matching slot, and the occupancy
  always_comb begin
    has_free  = 1'b0;
    has_match = 1'b0;
    free_idx  = '0;
    match_idx = '0;
    vld_cnt   = '0;
    // Walk from the top so the lowest slot is left standing
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (!rd0_data[i].vld) begin
        has_free = 1'b1;
        free_idx = idx_w'(i);
      end
      if (rd0_data[i].vld && (rd0_data[i].key == s1_cmd.key)) begin
        has_match = 1'b1;
        match_idx = idx_w'(i);
      end
      vld_cnt = vld_cnt + sorted_lists_pkg::listsize_t'(rd0_data[i].vld);
    end
  end

  // Opcode execution, builds the new row
  always_comb begin
    nxt       = rd0_data;
    err       = 1'b0;
    empty_ntf = 1'b0;
    case (s1_cmd.op)
      sorted_lists_pkg::OP_CLEAR: begin
        // Whole list gone, always notify
        nxt       = '0;
        empty_ntf = 1'b1;
      end
      sorted_lists_pkg::OP_ADD: begin
        // Full list has no free slot
        err           = !has_free;
        nxt[free_idx] = '{vld: 1'b1, key: s1_cmd.key, size: s1_cmd.size};
      end
      sorted_lists_pkg::OP_DELETE: begin
        err                = !has_match;
        nxt[match_idx].vld = 1'b0;
        // Last entry removed
        empty_ntf          = has_match && (vld_cnt == sorted_lists_pkg::listsize_t'(1));
      end
      sorted_lists_pkg::OP_REPLACE: begin
        // Key stays, size is overwritten
        err                 = !has_match;
        nxt[match_idx].size = s1_cmd.size;
      end
    endcase
  end

  // Write-back, an error leaves the list untouched
  assign wr_en   = s1_vld && !err;
  assign wr_addr = s1_cmd.id;
  assign wr_data = nxt;

  // Output strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      upt_error_vld <= 1'b0;
      ntf_vld       <= 1'b0;
    end else begin
      upt_error_vld <= s1_vld && err;
      ntf_vld       <= s1_vld && empty_ntf;
    end
  end

  // Output payloads
  always_ff @(posedge clk) begin
    if (s1_vld && err) begin
      upt_error_id <= s1_cmd.id;
    end
    if (s1_vld && empty_ntf) begin
      ntf <= '{id: s1_cmd.id, key: s1_cmd.key, size: s1_cmd.size};
    end
  end

endmodule

//--- hw/query_engine.sv
// Query pipeline: reads a list, ranks entries by key and returns the one at the requested level
`timescale 1ns/1ps

module query_engine #(
  parameter int num_entries = 8
) (
  input  logic                                       clk,
  input  logic                                       rst,
  // Query input
  input  logic                                       qry_vld,
  input  sorted_lists_pkg::qry_cmd_t                 qry,
  // Table read port 1
  output sorted_lists_pkg::id_t                      rd1_addr,
  input  sorted_lists_pkg::entry_t [num_entries-1:0] rd1_data,
  // Response
  output logic                                       qry_resp_vld,
  output sorted_lists_pkg::qry_resp_t                qry_resp
);

  // Stage 0 holds the query during the table read
  logic                        q0_vld;
  sorted_lists_pkg::qry_cmd_t  q0_cmd;
  // Stage 1 lines up with rd1_data
  logic                        q1_vld;
  sorted_lists_pkg::qry_cmd_t  q1_cmd;

  // Position of each slot in key order
  sorted_lists_pkg::listsize_t rank [num_entries];
  sorted_lists_pkg::listsize_t vld_cnt;
  logic                        hit;
  sorted_lists_pkg::entry_t    sel;
  sorted_lists_pkg::qry_resp_t resp;

  // Stage valids
  always_ff @(posedge clk) begin
    if (rst) begin
      q0_vld <= 1'b0;
      q1_vld <= 1'b0;
    end else begin
      q0_vld <= qry_vld;
      q1_vld <= q0_vld;
    end
  end

  // Stage payloads
  always_ff @(posedge clk) begin
    if (qry_vld) begin
      q0_cmd <= qry;
    end
    if (q0_vld) begin
      q1_cmd <= q0_cmd;
    end
  end

  assign rd1_addr = q0_cmd.id;

  // Rank = valid entries with a smaller key, plus equal keys in a lower slot
  // Ties resolved by slot so valid ranks are unique
  always_comb begin
    for (int i = 0; i < num_entries; i++) begin
      rank[i] = '0;
      for (int j = 0; j < num_entries; j++) begin
        if (rd1_data[j].vld &&
            ((rd1_data[j].key < rd1_data[i].key) ||
             ((rd1_data[j].key == rd1_data[i].key) && (j < i)))) begin
          rank[i] = rank[i] + sorted_lists_pkg::listsize_t'(1);
        end
      end
    end
  end

  // Occupancy count and level select
  always_comb begin
    vld_cnt = '0;
    hit     = 1'b0;
    sel     = '0;
    for (int i = 0; i < num_entries; i++) begin
      vld_cnt = vld_cnt + sorted_lists_pkg::listsize_t'(rd1_data[i].vld);
      // At most one valid slot carries a given rank
      if (rd1_data[i].vld && (rank[i] == q1_cmd.level)) begin
        hit = 1'b1;
        sel = rd1_data[i];
      end
    end
  end

  // Response fields, zeroed on a miss apart from the id
  always_comb begin
    resp.id       = q1_cmd.id;
    resp.key      = sel.key;
    resp.size     = sel.size;
    resp.error    = !hit;
    resp.listsize = hit ? vld_cnt : '0;
  end

  // Registered response
  always_ff @(posedge clk) begin
    if (rst) begin
      qry_resp_vld <= 1'b0;
    end else begin
      qry_resp_vld <= q1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (q1_vld) begin
      qry_resp <= resp;
    end
  end

endmodule

//--- hw/sorted_lists.sv
// Top level of the sorted list engine, connects update engine, list table and query engine
`timescale 1ns/1ps

module sorted_lists #(
  parameter int num_entries = 8,
  parameter int num_lists   = 64
) (
  input  logic                        clk,
  input  logic                        rst,
  // Update commands
  input  logic                        upt_vld,
  input  sorted_lists_pkg::upt_cmd_t  upt,
  // Queries
  input  logic                        qry_vld,
  input  sorted_lists_pkg::qry_cmd_t  qry,
  // Update error report
  output logic                        upt_error_vld,
  output sorted_lists_pkg::id_t       upt_error_id,
  // Query response
  output logic                        qry_resp_vld,
  output sorted_lists_pkg::qry_resp_t qry_resp,
  // Empty-list notification
  output logic                        ntf_vld,
  output sorted_lists_pkg::ntf_t      ntf
);

  // Update side of the table
  sorted_lists_pkg::id_t                      rd0_addr;
  sorted_lists_pkg::entry_t [num_entries-1:0] rd0_data;
  logic                                       wr_en;
  sorted_lists_pkg::id_t                      wr_addr;
  sorted_lists_pkg::entry_t [num_entries-1:0] wr_data;

  // Query side of the table
  sorted_lists_pkg::id_t                      rd1_addr;
  sorted_lists_pkg::entry_t [num_entries-1:0] rd1_data;

  // Producer
  update_engine #(.num_entries(num_entries)) u_update_engine (
    .clk          (clk),
    .rst          (rst),
    .upt_vld      (upt_vld),
    .upt          (upt),
    .rd0_addr     (rd0_addr),
    .rd0_data     (rd0_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .upt_error_vld(upt_error_vld),
    .upt_error_id (upt_error_id),
    .ntf_vld      (ntf_vld),
    .ntf          (ntf)
  );

  // Shared list state
  list_table #(.num_entries(num_entries), .num_lists(num_lists)) u_list_table (
    .clk     (clk),
    .rst     (rst),
    .rd0_addr(rd0_addr),
    .rd0_data(rd0_data),
    .rd1_addr(rd1_addr),
    .rd1_data(rd1_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // Consumer
  query_engine #(.num_entries(num_entries)) u_query_engine (
    .clk         (clk),
    .rst         (rst),
    .qry_vld     (qry_vld),
    .qry         (qry),
    .rd1_addr    (rd1_addr),
    .rd1_data    (rd1_data),
    .qry_resp_vld(qry_resp_vld),
    .qry_resp    (qry_resp)
  );

endmodule

//--- verification/tb_sorted_lists.sv
// Self-checking testbench for the sorted list engine that runs as the simulation top
`timescale 1ns/1ps

module tb_sorted_lists;

  localparam int num_entries = 8;
  localparam int num_lists   = 64;
  // Edges from the drive slot to the compare slot
  localparam int lat = 3;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        upt_vld;
  sorted_lists_pkg::upt_cmd_t  upt;
  logic                        qry_vld;
  sorted_lists_pkg::qry_cmd_t  qry;
  logic                        upt_error_vld;
  sorted_lists_pkg::id_t       upt_error_id;
  logic                        qry_resp_vld;
  sorted_lists_pkg::qry_resp_t qry_resp;
  logic                        ntf_vld;
  sorted_lists_pkg::ntf_t      ntf;

  // Reference list state
  logic                    model_vld  [num_lists][num_entries];
  sorted_lists_pkg::key_t  model_key  [num_lists][num_entries];
  sorted_lists_pkg::size_t model_size [num_lists][num_entries];

  // Expected outputs and the edge each is due on
  int                          err_due_q  [$];
  sorted_lists_pkg::id_t       err_id_q   [$];
  int                          ntf_due_q  [$];
  sorted_lists_pkg::ntf_t      ntf_exp_q  [$];
  int                          resp_due_q [$];
  sorted_lists_pkg::qry_resp_t resp_exp_q [$];
  // Read pointers owned by the comparing process
  int err_rd  = 0;
  int ntf_rd  = 0;
  int resp_rd = 0;

  int          edge_cnt     = 0;
  int          mismatch_cnt = 0;
  int          timeout_cnt  = 0;
  int          test_cnt     = 0;
  int          bad_test_cnt = 0;
  int          test_base    = 0;
  logic [31:0] lcg_state    = 32'd90025;
  sorted_lists_pkg::key_t saved_keys [6];

  sorted_lists #(.num_entries(num_entries), .num_lists(num_lists)) dut0 (
    .clk(clk), .rst(rst),
    .upt_vld(upt_vld), .upt(upt), .qry_vld(qry_vld), .qry(qry),
    .upt_error_vld(upt_error_vld), .upt_error_id(upt_error_id),
    .qry_resp_vld(qry_resp_vld), .qry_resp(qry_resp),
    .ntf_vld(ntf_vld), .ntf(ntf)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // Each value joins the upper halves of two LCG steps
  // Low state bits of an LCG repeat with a short period
  function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi        = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  // Key order with ties broken by the lower slot
  function automatic logic orders_before(input int id, input int a, input int b);
    return (model_key[id][a] < model_key[id][b]) ||
           ((model_key[id][a] == model_key[id][b]) && (a < b));
  endfunction

  // Applies one command to the model and predicts error and notification
  function automatic void model_update(input sorted_lists_pkg::upt_cmd_t c,
                                       output logic err, output logic notify);
    int free_slot;
    int match_slot;
    int cnt;
    free_slot  = -1;
    match_slot = -1;
    cnt        = 0;
    err        = 1'b0;
    notify     = 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      if (!model_vld[c.id][i] && free_slot < 0) free_slot = i;
      if (model_vld[c.id][i] && model_key[c.id][i] == c.key && match_slot < 0) match_slot = i;
      if (model_vld[c.id][i]) cnt++;
    end
    case (c.op)
      sorted_lists_pkg::OP_CLEAR: begin
        for (int i = 0; i < num_entries; i++) model_vld[c.id][i] = 1'b0;
        notify = 1'b1;
      end
      sorted_lists_pkg::OP_ADD: begin
        if (free_slot < 0) begin
          err = 1'b1;
        end else begin
          model_vld[c.id][free_slot]  = 1'b1;
          model_key[c.id][free_slot]  = c.key;
          model_size[c.id][free_slot] = c.size;
        end
      end
      sorted_lists_pkg::OP_DELETE: begin
        err = (match_slot < 0);
        if (!err) model_vld[c.id][match_slot] = 1'b0;
        // Empty after this delete
        notify = !err && (cnt == 1);
      end
      default: begin
        err = (match_slot < 0);
        if (!err) model_size[c.id][match_slot] = c.size;
      end
    endcase
  endfunction

  // Expected response by repeated minimum search over the model
  function automatic sorted_lists_pkg::qry_resp_t model_query(input sorted_lists_pkg::qry_cmd_t q);
    sorted_lists_pkg::qry_resp_t r;
    int cnt;
    int prev;
    int pick;
    r    = '0;
    r.id = q.id;
    cnt  = 0;
    prev = -1;
    pick = -1;
    for (int i = 0; i < num_entries; i++) begin
      if (model_vld[q.id][i]) cnt++;
    end
    if (int'(q.level) >= cnt) begin
      r.error = 1'b1;
    end else begin
      for (int step = 0; step <= int'(q.level); step++) begin
        pick = -1;
        for (int i = 0; i < num_entries; i++) begin
          if (model_vld[q.id][i] && (prev < 0 || orders_before(q.id, prev, i)) &&
              (pick < 0 || orders_before(q.id, i, pick))) pick = i;
        end
        prev = pick;
      end
      r.key      = model_key[q.id][pick];
      r.size     = model_size[q.id][pick];
      r.listsize = sorted_lists_pkg::listsize_t'(cnt);
    end
    return r;
  endfunction

  function automatic sorted_lists_pkg::upt_cmd_t make_upt(input sorted_lists_pkg::upt_op_t op,
      input int id, input sorted_lists_pkg::key_t key, input sorted_lists_pkg::size_t size);
    sorted_lists_pkg::upt_cmd_t c;
    c.id   = sorted_lists_pkg::id_t'(id);
    c.op   = op;
    c.key  = key;
    c.size = size;
    return c;
  endfunction

  function automatic sorted_lists_pkg::qry_cmd_t make_qry(input int id, input int level);
    sorted_lists_pkg::qry_cmd_t q;
    q.id    = sorted_lists_pkg::id_t'(id);
    q.level = sorted_lists_pkg::level_t'(level);
    return q;
  endfunction

  function automatic logic outputs_pending();
    return (err_rd < err_due_q.size()) || (ntf_rd < ntf_due_q.size()) ||
           (resp_rd < resp_due_q.size());
  endfunction

  // One input cycle
  // The query is predicted before the update lands
  task automatic drive_cycle(input logic do_upt, input sorted_lists_pkg::upt_cmd_t u,
                             input logic do_qry, input sorted_lists_pkg::qry_cmd_t q);
    logic err;
    logic notify;
    sorted_lists_pkg::ntf_t n;
    @(posedge clk);
    #1;
    if (do_qry) begin
      resp_due_q.push_back(edge_cnt + lat);
      resp_exp_q.push_back(model_query(q));
    end
    if (do_upt) begin
      model_update(u, err, notify);
      if (err) begin
        err_due_q.push_back(edge_cnt + lat);
        err_id_q.push_back(u.id);
      end
      if (notify) begin
        n.id   = u.id;
        n.key  = u.key;
        n.size = u.size;
        ntf_due_q.push_back(edge_cnt + lat);
        ntf_exp_q.push_back(n);
      end
    end
    upt_vld = do_upt;
    upt     = u;
    qry_vld = do_qry;
    qry     = q;
  endtask

  task automatic send_update(input sorted_lists_pkg::upt_op_t op, input int id,
                             input sorted_lists_pkg::key_t key, input sorted_lists_pkg::size_t size);
    drive_cycle(1'b1, make_upt(op, id, key, size), 1'b0, '0);
  endtask

  task automatic send_query(input int id, input int level);
    drive_cycle(1'b0, '0, 1'b1, make_qry(id, level));
  endtask

  // Idle the inputs and let every expected output arrive
  task automatic wait_outputs();
    int n;
    n = 0;
    drive_cycle(1'b0, '0, 1'b0, '0);
    while (outputs_pending() && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (outputs_pending()) begin
      $display("Timeout while waiting for expected DUT outputs");
      timeout_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    wait_outputs();
    errs = mismatch_cnt + timeout_cnt - test_base;
    test_cnt++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      bad_test_cnt++;
      $display("Test %0d %s: %0d errors", test_cnt, name, errs);
    end
    test_base = mismatch_cnt + timeout_cnt;
  endtask

  // Fill list 3
  // Only the extra ADD may raise an error
  task automatic fill_list();
    for (int i = 0; i <= num_entries; i++) begin
      send_update(sorted_lists_pkg::OP_ADD, 3, 64'h300 + 64'(i), 32'(i + 1));
    end
    end_test("fill list");
  endtask

  // Random keys into list 5 then every level and one past the end
  task automatic query_sorted();
    for (int i = 0; i < 6; i++) begin
      saved_keys[i] = {lcg_next(), lcg_next()};
      send_update(sorted_lists_pkg::OP_ADD, 5, saved_keys[i], lcg_next());
    end
    for (int l = 0; l <= num_entries; l++) send_query(5, l);
    end_test("sorted query");
  endtask

  task automatic delete_and_replace();
    send_update(sorted_lists_pkg::OP_DELETE, 5, 64'hdead_beef, 32'h0);
    send_update(sorted_lists_pkg::OP_REPLACE, 5, 64'hdead_beef, 32'h55);
    for (int l = 0; l <= 6; l++) send_query(5, l);
    send_update(sorted_lists_pkg::OP_REPLACE, 5, saved_keys[2], 32'hcafe_0002);
    for (int l = 0; l < 6; l++) send_query(5, l);
    // Last delete empties the list
    for (int i = 0; i < 6; i++) begin
      send_update(sorted_lists_pkg::OP_DELETE, 5, saved_keys[i], 32'h100 + 32'(i));
    end
    send_query(5, 0);
    end_test("delete and replace");
  endtask

  task automatic clear_lists();
    send_update(sorted_lists_pkg::OP_CLEAR, 9, 64'h99, 32'h9);
    send_update(sorted_lists_pkg::OP_CLEAR, 3, 64'h33, 32'h3);
    for (int l = 0; l < 3; l++) send_query(3, l);
    end_test("clear");
  endtask

  // Same-list updates every cycle with queries alongside
  task automatic back_to_back();
    for (int i = 0; i < 6; i++) begin
      drive_cycle(1'b1, make_upt(sorted_lists_pkg::OP_ADD, 12, 64'(60 - 10 * i), 32'(i)),
                  1'b1, make_qry(12, 0));
    end
    drive_cycle(1'b1, make_upt(sorted_lists_pkg::OP_DELETE, 12, 64'd30, 32'h0),
                1'b1, make_qry(12, 2));
    drive_cycle(1'b1, make_upt(sorted_lists_pkg::OP_ADD, 12, 64'd5, 32'h5),
                1'b1, make_qry(12, 2));
    drive_cycle(1'b1, make_upt(sorted_lists_pkg::OP_DELETE, 12, 64'd5, 32'h0),
                1'b1, make_qry(12, 0));
    drive_cycle(1'b1, make_upt(sorted_lists_pkg::OP_REPLACE, 12, 64'd60, 32'h77),
                1'b1, make_qry(12, 0));
    send_query(12, 4);
    end_test("back-to-back");
  endtask

  task automatic random_mix();
    logic [31:0] sel;
    logic        do_upt;
    logic        do_qry;
    sorted_lists_pkg::upt_op_t  op;
    sorted_lists_pkg::upt_cmd_t u;
    sorted_lists_pkg::qry_cmd_t q;
    for (int c = 0; c < 2000; c++) begin
      sel = lcg_next() % 16;
      // CLEAR is rare and ADD most common
      if (sel == 0) op = sorted_lists_pkg::OP_CLEAR;
      else if (sel < 8) op = sorted_lists_pkg::OP_ADD;
      else if (sel < 12) op = sorted_lists_pkg::OP_DELETE;
      else op = sorted_lists_pkg::OP_REPLACE;
      // Pool of 8 keys so matches and duplicates are frequent
      u = make_upt(op, int'(lcg_next() % 8), 64'h4000 + 64'(lcg_next() % 8), lcg_next());
      q = make_qry(int'(lcg_next() % 8), int'(lcg_next() % 10));
      do_upt = (lcg_next() % 4) != 0;
      do_qry = (lcg_next() % 2) != 0;
      drive_cycle(do_upt, u, do_qry, q);
    end
    end_test("random mix");
  endtask

  // Compare each output in the middle of the cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (upt_error_vld) begin
        if (err_rd >= err_due_q.size() || err_due_q[err_rd] != edge_cnt) begin
          $display("Unexpected upt_error_vld at edge %0d", edge_cnt);
          mismatch_cnt++;
        end else begin
          if (upt_error_id !== err_id_q[err_rd]) begin
            $display("Error: upt_error_id got %h expected %h", upt_error_id, err_id_q[err_rd]);
            mismatch_cnt++;
          end
          err_rd++;
        end
      end
      if (err_rd < err_due_q.size() && err_due_q[err_rd] <= edge_cnt) begin
        $display("Missing upt_error_vld due at edge %0d", err_due_q[err_rd]);
        mismatch_cnt++;
        err_rd++;
      end
      if (ntf_vld) begin
        if (ntf_rd >= ntf_due_q.size() || ntf_due_q[ntf_rd] != edge_cnt) begin
          $display("Unexpected ntf_vld at edge %0d", edge_cnt);
          mismatch_cnt++;
        end else begin
          if (ntf !== ntf_exp_q[ntf_rd]) begin
            $display("Error: ntf got %h expected %h", ntf, ntf_exp_q[ntf_rd]);
            mismatch_cnt++;
          end
          ntf_rd++;
        end
      end
      if (ntf_rd < ntf_due_q.size() && ntf_due_q[ntf_rd] <= edge_cnt) begin
        $display("Missing ntf_vld due at edge %0d", ntf_due_q[ntf_rd]);
        mismatch_cnt++;
        ntf_rd++;
      end
      if (qry_resp_vld) begin
        if (resp_rd >= resp_due_q.size() || resp_due_q[resp_rd] != edge_cnt) begin
          $display("Unexpected qry_resp_vld at edge %0d", edge_cnt);
          mismatch_cnt++;
        end else begin
          if (qry_resp !== resp_exp_q[resp_rd]) begin
            $display("Error: qry_resp got %h expected %h", qry_resp, resp_exp_q[resp_rd]);
            mismatch_cnt++;
          end
          resp_rd++;
        end
      end
      if (resp_rd < resp_due_q.size() && resp_due_q[resp_rd] <= edge_cnt) begin
        $display("Missing qry_resp_vld due at edge %0d", resp_due_q[resp_rd]);
        mismatch_cnt++;
        resp_rd++;
      end
    end
  end

  initial begin
    rst     = 1'b1;
    upt_vld = 1'b0;
    upt     = '0;
    qry_vld = 1'b0;
    qry     = '0;
    for (int l = 0; l < num_lists; l++) begin
      for (int e = 0; e < num_entries; e++) model_vld[l][e] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    fill_list();
    query_sorted();
    delete_and_replace();
    clear_lists();
    back_to_back();
    random_mix();
    $display("Tests run %0d, tests with errors %0d, errors %0d",
             test_cnt, bad_test_cnt, mismatch_cnt + timeout_cnt);
    if (mismatch_cnt + timeout_cnt == 0 && bad_test_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sources.f
hw/sorted_lists_pkg.sv
hw/list_table.sv
hw/update_engine.sv
hw/query_engine.sv
hw/sorted_lists.sv
verification/tb_sorted_lists.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing -j 0 -Mdir obj_dir
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_sorted_lists
RTL_TOP    := sorted_lists
FILELIST   := sources.f
LOG        := sim.log
PASS_MSG   := Verification passed

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
